// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Host command codes
    typedef enum logic [2:0] {
        CMD_READ,
        CMD_WRITE,
        CMD_PHA,
        CMD_PHP,
        CMD_PLA,
        CMD_PLP,
        CMD_BRK,
        CMD_NMI
    } cmd_op_t;

    // B and bit 5 exist only on the stack
    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

    typedef enum logic [2:0] {
        ADDRLO_CMD,
        ADDRLO_SP,
        ADDRLO_VEC_LO,
        ADDRLO_VEC_HI
    } addr_lo_src_t;

    typedef enum logic [2:0] {
        ADDRHI_CMD,
        ADDRHI_STACK,
        ADDRHI_FF
    } addr_hi_src_t;

    typedef enum logic [2:0] {
        WMEMSRC_CMD,
        WMEMSRC_A,
        WMEMSRC_STATUS_PHP,
        WMEMSRC_STATUS_INT,
        WMEMSRC_PCHI,
        WMEMSRC_PCLO
    } wmem_src_t;

    localparam logic [7:0] STACK_PAGE = 8'h01;
    localparam logic [7:0] SP_RESET = 8'hFD;

    // Exclusive region ends
    localparam logic [15:0] RAM_LIMIT = 16'h2000;
    localparam logic [15:0] PPU_LIMIT = 16'h4000;
    localparam logic [15:0] IO_LIMIT = 16'h4020;
    localparam logic [15:0] CART_BASE = 16'h4020;

endpackage : cpu_pkg

`default_nettype wire

// File: verilog/cpu_register.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_register #(
    parameter type payload_t = logic [7:0],
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     data_en,
    input  payload_t data_in,
    output payload_t data_out
);

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            data_out <= RESET_VAL;
        end
        else if (data_en) begin
            data_out <= data_in;
        end
    end

endmodule : cpu_register

`default_nettype wire

// File: verilog/cpu_wide_counter_register.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_wide_counter_register #(
    parameter logic [15:0] RESET_VAL = 16'h0000
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        inc_en,
    input  logic [1:0]  data_en,
    input  logic [15:0] data_in,
    output logic [15:0] data_out
);

    logic [15:0] loaded;

    // Byte lanes load independently
    always_comb begin
        loaded = data_out;
        if (data_en[0]) begin
            loaded[7:0] = data_in[7:0];
        end
        if (data_en[1]) begin
            loaded[15:8] = data_in[15:8];
        end
    end

    // Increment applies after the load
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            data_out <= RESET_VAL;
        end
        else begin
            data_out <= loaded + {15'b0, inc_en};
        end
    end

endmodule : cpu_wide_counter_register

`default_nettype wire

// File: verilog/mem_inputs.sv
`default_nettype none
`timescale 1ns/10ps

module mem_inputs (
    input  cpu_pkg::addr_lo_src_t addr_lo_sel,
    input  cpu_pkg::addr_hi_src_t addr_hi_sel,
    input  cpu_pkg::wmem_src_t    wmem_sel,
    input  logic [15:0]           cmd_addr,
    input  logic [7:0]            cmd_wdata,
    input  logic [7:0]            a_reg,
    input  logic [7:0]            sp,
    input  logic [15:0]           pc,
    input  cpu_pkg::status_t      status,
    input  logic                  nmi_active,
    input  logic                  sp_dec,
    input  logic                  sp_inc,
    output logic [15:0]           mem_addr,
    output logic [7:0]            mem_wdata,
    output logic [7:0]            sp_next
);

    always_comb begin
        case (addr_lo_sel)
            cpu_pkg::ADDRLO_SP:     mem_addr[7:0] = sp;
            cpu_pkg::ADDRLO_VEC_LO: mem_addr[7:0] = nmi_active ? 8'hFA : 8'hFE;
            cpu_pkg::ADDRLO_VEC_HI: mem_addr[7:0] = nmi_active ? 8'hFB : 8'hFF;
            default:                mem_addr[7:0] = cmd_addr[7:0];
        endcase
    end

    always_comb begin
        case (addr_hi_sel)
            cpu_pkg::ADDRHI_STACK: mem_addr[15:8] = cpu_pkg::STACK_PAGE;
            cpu_pkg::ADDRHI_FF:    mem_addr[15:8] = 8'hFF;
            default:               mem_addr[15:8] = cmd_addr[15:8];
        endcase
    end

    // Pushed status is NV1BDIZC
    always_comb begin
        case (wmem_sel)
            cpu_pkg::WMEMSRC_A: begin
                mem_wdata = a_reg;
            end
            cpu_pkg::WMEMSRC_STATUS_PHP: begin
                mem_wdata = {status.n, status.v, 1'b1, 1'b1,
                             status.d, status.i, status.z, status.c};
            end
            cpu_pkg::WMEMSRC_STATUS_INT: begin
                // B clear only for a hardware interrupt
                mem_wdata = {status.n, status.v, 1'b1, !nmi_active,
                             status.d, status.i, status.z, status.c};
            end
            cpu_pkg::WMEMSRC_PCHI: begin
                mem_wdata = pc[15:8];
            end
            cpu_pkg::WMEMSRC_PCLO: begin
                mem_wdata = pc[7:0];
            end
            default: begin
                mem_wdata = cmd_wdata;
            end
        endcase
    end

    // Stack pointer wraps within page one
    always_comb begin
        sp_next = sp;
        if (sp_dec) begin
            sp_next = sp - 8'd1;
        end
        else if (sp_inc) begin
            sp_next = sp + 8'd1;
        end
    end

    a_sp_one_direction: assert #0 (!(sp_dec && sp_inc))
        else $error("stack pointer moved both ways at once");

endmodule : mem_inputs

`default_nettype wire

// File: verilog/cpu_memory.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_memory (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [15:0] addr,
    input  logic        r_en,
    input  logic        w_en,
    input  logic [7:0]  w_data,
    output logic [7:0]  r_data
);

    logic [7:0] ram_mem [2047:0];
    logic [7:0] ppu_mem [7:0];
    logic [7:0] io_mem [31:0];
    logic [7:0] cart_mem [16'hFFFF:cpu_pkg::CART_BASE];

    logic in_ram;
    logic in_ppu;
    logic in_io;

    // Regions checked low to high so the cartridge takes the rest
    assign in_ram = addr < cpu_pkg::RAM_LIMIT;
    assign in_ppu = !in_ram && (addr < cpu_pkg::PPU_LIMIT);
    assign in_io = !in_ram && !in_ppu && (addr < cpu_pkg::IO_LIMIT);

    // Mirrors fall out of the truncated index
    always_ff @(posedge clock) begin
        if (w_en) begin
            if (in_ram) begin
                ram_mem[addr[10:0]] <= w_data;
            end
            else if (in_ppu) begin
                ppu_mem[addr[2:0]] <= w_data;
            end
            else if (in_io) begin
                io_mem[addr[4:0]] <= w_data;
            end
            else begin
                cart_mem[addr] <= w_data;
            end
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            r_data <= 8'h00;
        end
        else if (r_en) begin
            if (in_ram) begin
                r_data <= ram_mem[addr[10:0]];
            end
            else if (in_ppu) begin
                r_data <= ppu_mem[addr[2:0]];
            end
            else if (in_io) begin
                r_data <= io_mem[addr[4:0]];
            end
            else begin
                r_data <= cart_mem[addr];
            end
        end
    end

    a_no_read_write: assert property (
        @(posedge clock) disable iff (!reset_n) !(r_en && w_en)
    ) else $error("read and write in the same memory cycle");

endmodule : cpu_memory

`default_nettype wire

// File: verilog/cpu_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_sequencer (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  req,
    input  cpu_pkg::cmd_op_t      op,
    output logic                  ack,
    output cpu_pkg::addr_lo_src_t addr_lo_sel,
    output cpu_pkg::addr_hi_src_t addr_hi_sel,
    output cpu_pkg::wmem_src_t    wmem_sel,
    output logic                  mem_r_en,
    output logic                  mem_w_en,
    output logic                  a_en,
    output logic                  status_en,
    output logic                  set_i,
    output logic                  sp_en,
    output logic                  sp_dec,
    output logic                  sp_inc,
    output logic [1:0]            pc_byte_en,
    output logic                  nmi_active
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_ACK
    } seq_state_t;

    seq_state_t       state;
    logic [2:0]       step;
    logic [2:0]       last_step;
    cpu_pkg::cmd_op_t op_q;

    always_comb begin
        case (op_q)
            cpu_pkg::CMD_READ:                   last_step = 3'd1;
            cpu_pkg::CMD_PLA, cpu_pkg::CMD_PLP:  last_step = 3'd2;
            cpu_pkg::CMD_BRK, cpu_pkg::CMD_NMI:  last_step = 3'd6;
            default:                             last_step = 3'd0;
        endcase
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state <= S_IDLE;
            step <= 3'd0;
            op_q <= cpu_pkg::CMD_READ;
        end
        else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_RUN;
                        step <= 3'd0;
                        op_q <= op;
                    end
                end
                S_RUN: begin
                    if (step == last_step) begin
                        state <= S_ACK;
                    end
                    else begin
                        step <= step + 3'd1;
                    end
                end
                default: begin
                    // Hold ack until the host lets go
                    if (!req) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    assign ack = (state == S_ACK);
    assign nmi_active = (op_q == cpu_pkg::CMD_NMI);
    assign sp_en = sp_dec || sp_inc;

    // Micro-step table
    always_comb begin
        addr_lo_sel = cpu_pkg::ADDRLO_CMD;
        addr_hi_sel = cpu_pkg::ADDRHI_CMD;
        wmem_sel = cpu_pkg::WMEMSRC_CMD;
        mem_r_en = 1'b0;
        mem_w_en = 1'b0;
        a_en = 1'b0;
        status_en = 1'b0;
        set_i = 1'b0;
        sp_dec = 1'b0;
        sp_inc = 1'b0;
        pc_byte_en = 2'b00;
        if (state == S_RUN) begin
            case (op_q)
                cpu_pkg::CMD_READ: begin
                    mem_r_en = (step == 3'd0);
                    a_en = (step != 3'd0);
                end
                cpu_pkg::CMD_WRITE: begin
                    mem_w_en = 1'b1;
                end
                cpu_pkg::CMD_PHA, cpu_pkg::CMD_PHP: begin
                    addr_lo_sel = cpu_pkg::ADDRLO_SP;
                    addr_hi_sel = cpu_pkg::ADDRHI_STACK;
                    wmem_sel = (op_q == cpu_pkg::CMD_PHA) ? cpu_pkg::WMEMSRC_A
                                                          : cpu_pkg::WMEMSRC_STATUS_PHP;
                    mem_w_en = 1'b1;
                    sp_dec = 1'b1;
                end
                cpu_pkg::CMD_PLA, cpu_pkg::CMD_PLP: begin
                    // Pre-increment, read, then load
                    addr_lo_sel = cpu_pkg::ADDRLO_SP;
                    addr_hi_sel = cpu_pkg::ADDRHI_STACK;
                    sp_inc = (step == 3'd0);
                    mem_r_en = (step == 3'd1);
                    if (step == 3'd2) begin
                        a_en = (op_q == cpu_pkg::CMD_PLA);
                        status_en = (op_q == cpu_pkg::CMD_PLP);
                    end
                end
                default: begin
                    case (step)
                        3'd0, 3'd1, 3'd2: begin
                            addr_lo_sel = cpu_pkg::ADDRLO_SP;
                            addr_hi_sel = cpu_pkg::ADDRHI_STACK;
                            mem_w_en = 1'b1;
                            sp_dec = 1'b1;
                            if (step == 3'd0) begin
                                wmem_sel = cpu_pkg::WMEMSRC_PCHI;
                            end
                            else if (step == 3'd1) begin
                                wmem_sel = cpu_pkg::WMEMSRC_PCLO;
                            end
                            else begin
                                wmem_sel = cpu_pkg::WMEMSRC_STATUS_INT;
                            end
                        end
                        3'd3: begin
                            addr_lo_sel = cpu_pkg::ADDRLO_VEC_LO;
                            addr_hi_sel = cpu_pkg::ADDRHI_FF;
                            mem_r_en = 1'b1;
                        end
                        3'd4: begin
                            // Low vector byte lands while the high one is read
                            pc_byte_en = 2'b01;
                            addr_lo_sel = cpu_pkg::ADDRLO_VEC_HI;
                            addr_hi_sel = cpu_pkg::ADDRHI_FF;
                            mem_r_en = 1'b1;
                        end
                        3'd5: begin
                            pc_byte_en = 2'b10;
                        end
                        default: begin
                            status_en = 1'b1;
                            set_i = 1'b1;
                        end
                    endcase
                end
            endcase
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clock) disable iff (!reset_n) $rose(ack) |-> $past(req)
    ) else $error("ack raised without a pending request");

    a_op_stable: assert property (
        @(posedge clock) disable iff (!reset_n) (state == S_RUN) && req |-> (op == op_q)
    ) else $error("op changed while the request was pending");

endmodule : cpu_sequencer

`default_nettype wire

// File: verilog/cpu_stack_top.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_stack_top (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             req,
    input  cpu_pkg::cmd_op_t op,
    input  logic [15:0]      addr,
    input  logic [7:0]       wdata,
    output logic             ack,
    output logic [7:0]       a_reg,
    output cpu_pkg::status_t status,
    output logic [15:0]      pc,
    output logic [7:0]       sp
);

    cpu_pkg::addr_lo_src_t addr_lo_sel;
    cpu_pkg::addr_hi_src_t addr_hi_sel;
    cpu_pkg::wmem_src_t    wmem_sel;
    cpu_pkg::status_t      status_d;

    logic        mem_r_en;
    logic        mem_w_en;
    logic        a_en;
    logic        status_en;
    logic        set_i;
    logic        sp_en;
    logic        sp_dec;
    logic        sp_inc;
    logic        nmi_active;
    logic [1:0]  pc_byte_en;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;
    logic [7:0]  sp_next;
    logic [7:0]  r_data;

    cpu_sequencer u_seq (
        .clock(clock), .reset_n(reset_n), .req(req), .op(op), .ack(ack),
        .addr_lo_sel(addr_lo_sel), .addr_hi_sel(addr_hi_sel), .wmem_sel(wmem_sel),
        .mem_r_en(mem_r_en), .mem_w_en(mem_w_en), .a_en(a_en), .status_en(status_en),
        .set_i(set_i), .sp_en(sp_en), .sp_dec(sp_dec), .sp_inc(sp_inc),
        .pc_byte_en(pc_byte_en), .nmi_active(nmi_active)
    );

    mem_inputs u_mem_in (
        .addr_lo_sel(addr_lo_sel), .addr_hi_sel(addr_hi_sel), .wmem_sel(wmem_sel),
        .cmd_addr(addr), .cmd_wdata(wdata), .a_reg(a_reg), .sp(sp), .pc(pc),
        .status(status), .nmi_active(nmi_active), .sp_dec(sp_dec), .sp_inc(sp_inc),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .sp_next(sp_next)
    );

    cpu_memory u_mem (
        .clock(clock), .reset_n(reset_n), .addr(mem_addr), .r_en(mem_r_en),
        .w_en(mem_w_en), .w_data(mem_wdata), .r_data(r_data)
    );

    // Pulled status drops bits 5 and 4
    always_comb begin
        if (set_i) begin
            status_d = status;
            status_d.i = 1'b1;
        end
        else begin
            status_d = {r_data[7:6], r_data[3:0]};
        end
    end

    cpu_register #(.payload_t(logic [7:0]), .RESET_VAL(8'h00)) u_a_reg (
        .clock(clock), .reset_n(reset_n), .data_en(a_en), .data_in(r_data),
        .data_out(a_reg)
    );

    cpu_register #(.payload_t(logic [7:0]), .RESET_VAL(cpu_pkg::SP_RESET)) u_sp_reg (
        .clock(clock), .reset_n(reset_n), .data_en(sp_en), .data_in(sp_next),
        .data_out(sp)
    );

    cpu_register #(.payload_t(cpu_pkg::status_t), .RESET_VAL('0)) u_status_reg (
        .clock(clock), .reset_n(reset_n), .data_en(status_en), .data_in(status_d),
        .data_out(status)
    );

    // No fetch here, so the PC only loads vector bytes
    cpu_wide_counter_register #(.RESET_VAL(16'h0000)) u_pc (
        .clock(clock), .reset_n(reset_n), .inc_en(1'b0), .data_en(pc_byte_en),
        .data_in({r_data, r_data}), .data_out(pc)
    );

endmodule : cpu_stack_top

`default_nettype wire

// File: sim/cpu_stack_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_stack_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int ACK_LIMIT = 20;
    localparam int MIRROR_CMDS = 200;
    localparam int STACK_CMDS = 200;
    localparam int STATUS_ROUNDS = 16;
    localparam int VECTOR_ROUNDS = 16;
    localparam int MAX_COMMANDS = MIRROR_CMDS + STACK_CMDS + 4 * STATUS_ROUNDS
                                  + 10 * VECTOR_ROUNDS;
    localparam int WATCHDOG_NS = (MAX_COMMANDS * 20 + RESET_CYCLES) * CLK_PERIOD;

    logic             clock = 1'b0;
    logic             reset_n;
    logic             req;
    cpu_pkg::cmd_op_t op;
    logic [15:0]      addr;
    logic [7:0]       wdata;
    logic             ack;
    logic [7:0]       a_reg;
    cpu_pkg::status_t status;
    logic [15:0]      pc;
    logic [7:0]       sp;

    // Reference model state
    logic [7:0]       model_mem [0:65535];
    bit               model_valid [0:65535];
    logic [15:0]      written_q [$];
    logic [7:0]       m_a;
    logic [7:0]       m_sp;
    logic [15:0]      m_pc;
    cpu_pkg::status_t m_status;
    logic [31:0]      rng_state = 32'd29232;

    cpu_stack_top dut (
        .clock(clock), .reset_n(reset_n), .req(req), .op(op), .addr(addr),
        .wdata(wdata), .ack(ack), .a_reg(a_reg), .status(status), .pc(pc), .sp(sp)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the handshake hung", $time);
        $display("Test failures found");
        $fatal(1, "run exceeded its time limit");
    end

    function automatic logic [31:0] lcg_next();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi = rng_state[31:16];
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi, rng_state[31:16]};
    endfunction

    // Half the addresses land in the mirrored RAM and PPU space
    function automatic logic [15:0] pick_addr();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:30])
            2'd2: return 16'h4000 + {11'd0, r[4:0]};
            2'd3: return cpu_pkg::CART_BASE + (r[15:0] % 16'hBFE0);
            default: return {2'b00, r[13:0]};
        endcase
    endfunction

    function automatic logic [15:0] mirror_index(input logic [15:0] a);
        if (a < cpu_pkg::RAM_LIMIT) begin
            return {5'd0, a[10:0]};
        end
        else if (a < cpu_pkg::PPU_LIMIT) begin
            return {13'h0400, a[2:0]};
        end
        return a;
    endfunction

    // Another address that reaches the same location
    function automatic logic [15:0] mirror_alias(input logic [15:0] a, input logic [31:0] r);
        if (a < cpu_pkg::RAM_LIMIT) begin
            return {3'b000, r[1:0], a[10:0]};
        end
        else if (a < cpu_pkg::PPU_LIMIT) begin
            return {3'b001, r[9:0], a[2:0]};
        end
        return a;
    endfunction

    function automatic logic [7:0] pushed_status(input cpu_pkg::status_t s, input logic b_flag);
        return {s.n, s.v, 1'b1, b_flag, s.d, s.i, s.z, s.c};
    endfunction

    function automatic int cycles_for(input cpu_pkg::cmd_op_t cmd);
        case (cmd)
            cpu_pkg::CMD_WRITE, cpu_pkg::CMD_PHA, cpu_pkg::CMD_PHP: return 1;
            cpu_pkg::CMD_READ: return 2;
            cpu_pkg::CMD_PLA, cpu_pkg::CMD_PLP: return 3;
            default: return 7;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic handshake_error(input string msg);
        $display("handshake error at %0t: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %04h, expected %04h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_status(input cpu_pkg::status_t got, input cpu_pkg::status_t exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %06b, expected %06b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_state();
        check_byte(a_reg, m_a, "accumulator");
        check_byte(sp, m_sp, "stack pointer");
        check_word(pc, m_pc, "program counter");
        check_status(status, m_status, "status register");
    endtask

    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        model_mem[mirror_index(a)] = d;
        model_valid[mirror_index(a)] = 1'b1;
        written_q.push_back(a);
    endtask

    task automatic model_push(input logic [7:0] d);
        model_write({cpu_pkg::STACK_PAGE, m_sp}, d);
        m_sp = m_sp - 8'd1;
    endtask

    task automatic model_apply(input cpu_pkg::cmd_op_t cmd, input logic [15:0] a,
                               input logic [7:0] d);
        logic [7:0]  b;
        logic [15:0] vec;
        case (cmd)
            cpu_pkg::CMD_READ: m_a = model_mem[mirror_index(a)];
            cpu_pkg::CMD_WRITE: model_write(a, d);
            cpu_pkg::CMD_PHA: model_push(m_a);
            cpu_pkg::CMD_PHP: model_push(pushed_status(m_status, 1'b1));
            cpu_pkg::CMD_PLA, cpu_pkg::CMD_PLP: begin
                m_sp = m_sp + 8'd1;
                b = model_mem[{cpu_pkg::STACK_PAGE, m_sp}];
                if (cmd == cpu_pkg::CMD_PLA) begin
                    m_a = b;
                end
                else begin
                    // Bits 5 and 4 have no storage
                    m_status = {b[7:6], b[3:0]};
                end
            end
            default: begin
                vec = (cmd == cpu_pkg::CMD_NMI) ? 16'hFFFA : 16'hFFFE;
                model_push(m_pc[15:8]);
                model_push(m_pc[7:0]);
                model_push(pushed_status(m_status, cmd == cpu_pkg::CMD_BRK));
                m_status.i = 1'b1;
                m_pc = {model_mem[mirror_index(vec + 16'd1)], model_mem[mirror_index(vec)]};
            end
        endcase
    endtask

    // Four-phase handshake entered and left 1 ns after a rising edge
    task automatic run_command(input cpu_pkg::cmd_op_t cmd, input logic [15:0] a,
                               input logic [7:0] d);
        int cycles;
        int extra;
        if (ack) begin
            handshake_error("ack high before the request");
        end
        op = cmd;
        addr = a;
        wdata = d;
        req = 1'b1;
        @(posedge clock);
        #1;
        cycles = 0;
        while (!ack && cycles < ACK_LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!ack) begin
            handshake_error($sformatf("no ack for %s", cmd.name()));
        end
        if (cycles != cycles_for(cmd)) begin
            handshake_error($sformatf("%s took %0d cycles instead of %0d",
                                      cmd.name(), cycles, cycles_for(cmd)));
        end
        extra = lcg_next() % 4;
        repeat (extra) begin
            @(posedge clock);
            #1;
            if (!ack) begin
                handshake_error("ack dropped while req was still high");
            end
        end
        req = 1'b0;
        @(posedge clock);
        #1;
        if (ack) begin
            handshake_error("ack still high one edge after req fell");
        end
    endtask

    task automatic issue(input cpu_pkg::cmd_op_t cmd, input logic [15:0] a, input logic [7:0] d);
        run_command(cmd, a, d);
        model_apply(cmd, a, d);
        check_state();
    endtask

    function automatic logic [15:0] written_alias();
        logic [31:0] r;
        r = lcg_next();
        return mirror_alias(written_q[r % written_q.size()], lcg_next());
    endfunction

    task automatic mirror_phase();
        logic [31:0] r;
        repeat (MIRROR_CMDS) begin
            r = lcg_next();
            if (r[0] || written_q.size() == 0) begin
                issue(cpu_pkg::CMD_WRITE, pick_addr(), r[15:8]);
            end
            else begin
                issue(cpu_pkg::CMD_READ, written_alias(), 8'h00);
            end
        end
    endtask

    task automatic stack_phase();
        logic [31:0] r;
        logic [15:0] slot;
        repeat (STACK_CMDS) begin
            r = lcg_next();
            slot = {cpu_pkg::STACK_PAGE, m_sp + 8'd1};
            case (r[2:0])
                3'd0: issue(cpu_pkg::CMD_PHA, 16'h0000, 8'h00);
                3'd1: issue(cpu_pkg::CMD_PHP, 16'h0000, 8'h00);
                3'd2, 3'd3, 3'd6: begin
                    // Pull only from a slot that holds known data
                    if (!model_valid[slot]) begin
                        issue(r[3] ? cpu_pkg::CMD_PHP : cpu_pkg::CMD_PHA, 16'h0000, 8'h00);
                    end
                    else begin
                        issue(r[3] ? cpu_pkg::CMD_PLP : cpu_pkg::CMD_PLA, 16'h0000, 8'h00);
                    end
                end
                3'd5: issue(cpu_pkg::CMD_READ, written_alias(), 8'h00);
                default: issue(cpu_pkg::CMD_WRITE, mirror_alias(slot, r >> 8), r[23:16]);
            endcase
        end
    endtask

    task automatic pushed_status_phase();
        logic [31:0] r;
        logic [15:0] slot;
        repeat (STATUS_ROUNDS) begin
            r = lcg_next();
            slot = {cpu_pkg::STACK_PAGE, m_sp + 8'd1};
            issue(cpu_pkg::CMD_WRITE, mirror_alias(slot, r >> 8), r[7:0]);
            issue(cpu_pkg::CMD_PLP, 16'h0000, 8'h00);
            issue(cpu_pkg::CMD_PHP, 16'h0000, 8'h00);
            issue(cpu_pkg::CMD_READ, slot, 8'h00);
            check_byte(a_reg, {r[7:6], 2'b11, r[3:0]}, "status byte pushed by PHP");
        end
    endtask

    task automatic interrupt_phase();
        logic [31:0]      r;
        logic [7:0]       vec_byte [4];
        logic [15:0]      pc_before;
        logic [7:0]       sp_before;
        cpu_pkg::status_t st_before;
        cpu_pkg::status_t st_after;
        logic             is_nmi;
        repeat (VECTOR_ROUNDS) begin
            r = lcg_next();
            vec_byte[0] = r[7:0];
            vec_byte[1] = r[15:8];
            vec_byte[2] = r[23:16];
            vec_byte[3] = r[31:24];
            issue(cpu_pkg::CMD_WRITE, 16'hFFFA, vec_byte[0]);
            issue(cpu_pkg::CMD_WRITE, 16'hFFFB, vec_byte[1]);
            issue(cpu_pkg::CMD_WRITE, 16'hFFFE, vec_byte[2]);
            issue(cpu_pkg::CMD_WRITE, 16'hFFFF, vec_byte[3]);
            r = lcg_next();
            issue(cpu_pkg::CMD_WRITE, {cpu_pkg::STACK_PAGE, m_sp + 8'd1}, r[7:0]);
            issue(cpu_pkg::CMD_PLP, 16'h0000, 8'h00);
            pc_before = m_pc;
            sp_before = m_sp;
            st_before = m_status;
            is_nmi = r[8];
            issue(is_nmi ? cpu_pkg::CMD_NMI : cpu_pkg::CMD_BRK, 16'h0000, 8'h00);
            check_word(pc, is_nmi ? {vec_byte[1], vec_byte[0]} : {vec_byte[3], vec_byte[2]},
                       "program counter after interrupt entry");
            check_byte(sp, sp_before - 8'd3, "stack pointer after interrupt entry");
            st_after = st_before;
            st_after.i = 1'b1;
            check_status(status, st_after, "status after interrupt entry");
            issue(cpu_pkg::CMD_READ, mirror_alias({cpu_pkg::STACK_PAGE, sp_before}, r >> 16),
                  8'h00);
            check_byte(a_reg, pc_before[15:8], "pushed PCH");
            issue(cpu_pkg::CMD_READ, {cpu_pkg::STACK_PAGE, sp_before - 8'd1}, 8'h00);
            check_byte(a_reg, pc_before[7:0], "pushed PCL");
            issue(cpu_pkg::CMD_READ, {cpu_pkg::STACK_PAGE, sp_before - 8'd2}, 8'h00);
            check_byte(a_reg, pushed_status(st_before, !is_nmi), "pushed interrupt status");
        end
    endtask

    initial begin
        reset_n = 1'b0;
        req = 1'b0;
        op = cpu_pkg::CMD_READ;
        addr = 16'h0000;
        wdata = 8'h00;
        m_a = 8'h00;
        m_sp = cpu_pkg::SP_RESET;
        m_pc = 16'h0000;
        m_status = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(posedge clock);
        #1;
        if (ack) begin
            handshake_error("ack high after reset");
        end
        check_state();
        mirror_phase();
        stack_phase();
        pushed_status_phase();
        interrupt_phase();
        $display("All tests passed!");
        $finish;
    end

endmodule : cpu_stack_tb

`default_nettype wire

// File: src.f
verilog/cpu_pkg.sv
verilog/cpu_register.sv
verilog/cpu_wide_counter_register.sv
verilog/mem_inputs.sv
verilog/cpu_memory.sv
verilog/cpu_sequencer.sv
verilog/cpu_stack_top.sv
sim/cpu_stack_tb.sv
